// File: build.f
rx_frontend_pkg.sv
frontend_settings.sv
iq_mapper.sv
dc_offset_corr.sv
iq_imbalance_comp.sv
quarter_rate_dc.sv
rx_frontend_channel.sv
rx_sample_collector.sv
rx_frontend_top.sv
tb_rx_frontend.sv

// File: tb_rx_frontend.sv
// RX frontend testbench
`timescale 1ns/1ps
module tb_rx_frontend;

  localparam int NC = rx_frontend_pkg::NUM_CHAN;
  localparam int AW = rx_frontend_pkg::ADC_W;

  // Upper bounds on the stimulus, used to size the watchdog
  localparam int NUM_SAMPLES = 260;
  localparam int NUM_BURSTS  = 45;
  localparam int NUM_WRITES  = 70;
  localparam int STIM_CYCLES = 5 + 2 * NUM_SAMPLES + NUM_BURSTS * (rx_frontend_pkg::PIPE_LAT + 3)
                               + 2 * NUM_WRITES;
  localparam int TIMEOUT_NS  = STIM_CYCLES * 10 + 2000;

  logic             clk;
  logic             reset;
  logic             sync;
  logic             set_stb;
  logic [7:0]       set_addr;
  logic [31:0]      set_data;
  logic             adc_stb;
  logic [NC*AW-1:0] adc_i;
  logic [NC*AW-1:0] adc_q;
  logic             rx_stb;
  logic [NC*AW-1:0] rx_i;
  logic [NC*AW-1:0] rx_q;
  logic [31:0]      rx_count;

  // Reference model state with one entry per channel
  longint     m_mag [NC];
  longint     m_phc [NC];
  longint     m_off_i [NC];
  longint     m_off_q [NC];
  logic [7:0] m_map [NC];
  logic       m_dir [NC];
  int         m_nco [NC];

  // Expected outputs wait here in arrival order
  logic [NC*AW-1:0] exp_i_q [$];
  logic [NC*AW-1:0] exp_q_q [$];
  int               exp_cyc_q [$];
  logic [NC*AW-1:0] e_i;
  logic [NC*AW-1:0] e_q;
  int               e_cyc;

  logic [31:0] rng_state = 32'd11;
  int          cycle = 0;
  int          sent = 0;
  int          delivered = 0;
  int          mism_errs = 0;
  int          other_errs = 0;

  rx_frontend_top dut_i (
    .clk(clk), .reset(reset), .sync_i(sync), .set_stb_i(set_stb), .set_addr_i(set_addr),
    .set_data_i(set_data), .adc_stb_i(adc_stb), .adc_i_i(adc_i), .adc_q_i(adc_q),
    .rx_stb_o(rx_stb), .rx_i_o(rx_i), .rx_q_o(rx_q), .rx_count_o(rx_count)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Linear congruential generator with 32-bit wraparound
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // Upper half of the generator word has the better randomness
  function automatic logic [NC*AW-1:0] rand_vec();
    logic [NC*AW-1:0] v;
    logic [31:0]      r;
    for (int c = 0; c < NC; c++) begin
      r = next_rand();
      v[c*AW +: AW] = r[31:16];
    end
    return v;
  endfunction

  // Signed 24-bit clamp of the internal datapath
  function automatic longint clamp_dsp(input longint v);
    if (v > 64'sd8388607) begin
      return 64'sd8388607;
    end else if (v < -64'sd8388608) begin
      return -64'sd8388608;
    end
    return v;
  endfunction

  // Round half up to 16 bits where only the top end can overflow
  function automatic logic [AW-1:0] round16(input longint v);
    longint r;
    r = (v + 128) >>> 8;
    if (r > 32767) begin
      r = 32767;
    end
    return 16'(r);
  endfunction

  // Expected output of one channel for one ADC sample at mixer phase n
  function automatic void model_channel(input int c, input logic [AW-1:0] ai,
                                        input logic [AW-1:0] aq, input int n,
                                        output logic [AW-1:0] ei, output logic [AW-1:0] eq);
    rx_frontend_pkg::iq_map_t mp;
    logic [AW-1:0] xi;
    logic [AW-1:0] xq;
    logic [AW-1:0] yi;
    logic [AW-1:0] yq;
    longint        si;
    longint        sq;
    longint        top;
    longint        ti;
    longint        tq;
    int            sel;
    mp = m_map[c];
    // Inversion belongs to the input rail, then the rails may swap
    xi = mp.invert_i ? ~ai : ai;
    xq = mp.invert_q ? ~aq : aq;
    yi = mp.swap_iq ? xq : xi;
    yq = mp.swap_iq ? xi : xq;
    if (mp.realmode) begin
      yq = '0;
    end
    si = longint'($signed(yi)) * 256;
    sq = longint'($signed(yq)) * 256;
    si = clamp_dsp(si - m_off_i[c]);
    sq = clamp_dsp(sq - m_off_q[c]);
    // Both corrections scale the top 18 bits of I and drop 11 bits
    top = si >>> 6;
    ti = clamp_dsp(si + ((top * m_mag[c]) >>> 11));
    tq = clamp_dsp(sq + ((top * m_phc[c]) >>> 11));
    si = ti;
    sq = tq;
    if (mp.downconvert) begin
      sel = m_dir[c] ? (4 - n) % 4 : n % 4;
      case (sel)
        1: begin
          si = clamp_dsp(-tq);
          sq = ti;
        end
        2: begin
          si = clamp_dsp(-ti);
          sq = clamp_dsp(-tq);
        end
        3: begin
          si = tq;
          sq = clamp_dsp(-ti);
        end
        default: begin
        end
      endcase
    end
    ei = mp.bypass_all ? ai : round16(si);
    eq = mp.bypass_all ? aq : round16(sq);
  endfunction

  // Register write through the settings bus that is mirrored into the model
  task automatic write_reg(input int ch, input logic [3:0] idx, input logic [31:0] data);
    rx_frontend_pkg::set_word_u w;
    @(negedge clk);
    set_stb  = 1'b1;
    set_addr = {4'(ch), idx};
    set_data = data;
    w = data;
    if (ch < NC) begin
      case (idx)
        rx_frontend_pkg::SR_MAG: begin
          m_mag[ch] = longint'($signed(w.coef.value));
        end
        rx_frontend_pkg::SR_PHASE: begin
          m_phc[ch] = longint'($signed(w.coef.value));
        end
        rx_frontend_pkg::SR_OFFSET_I: begin
          m_off_i[ch] = longint'($signed(data[23:0]));
        end
        rx_frontend_pkg::SR_OFFSET_Q: begin
          m_off_q[ch] = longint'($signed(data[23:0]));
        end
        rx_frontend_pkg::SR_IQ_MAP: begin
          m_map[ch] = w.mapping.map;
        end
        rx_frontend_pkg::SR_HET_DIR: begin
          m_dir[ch] = data[0];
          m_nco[ch] = 0;
        end
        default: begin
        end
      endcase
    end
    @(negedge clk);
    set_stb = 1'b0;
  endtask

  task automatic pulse_sync();
    @(negedge clk);
    sync = 1'b1;
    for (int c = 0; c < NC; c++) begin
      m_nco[c] = 0;
    end
    @(negedge clk);
    sync = 1'b0;
  endtask

  // Strobe stays high, so consecutive calls give back-to-back samples
  task automatic send_sample(input logic [NC*AW-1:0] iv, input logic [NC*AW-1:0] qv);
    logic [NC*AW-1:0] ei;
    logic [NC*AW-1:0] eq;
    logic [AW-1:0]    oi;
    logic [AW-1:0]    oq;
    @(negedge clk);
    adc_stb = 1'b1;
    adc_i   = iv;
    adc_q   = qv;
    for (int c = 0; c < NC; c++) begin
      model_channel(c, iv[c*AW +: AW], qv[c*AW +: AW], m_nco[c], oi, oq);
      ei[c*AW +: AW] = oi;
      eq[c*AW +: AW] = oq;
      // The mixer phase moves on every sample whether the mixer is on or not
      m_nco[c] = (m_nco[c] + 1) % 4;
    end
    exp_i_q.push_back(ei);
    exp_q_q.push_back(eq);
    exp_cyc_q.push_back(cycle + rx_frontend_pkg::PIPE_LAT);
    sent++;
  endtask

  // Drop the strobe and let the pipeline empty before settings change
  task automatic finish_burst();
    @(negedge clk);
    adc_stb = 1'b0;
    while (exp_cyc_q.size() > 0) begin
      @(negedge clk);
    end
  endtask

  task automatic send_random(input int n, input bit gap);
    for (int k = 0; k < n; k++) begin
      send_sample(rand_vec(), rand_vec());
      if (gap) begin
        @(negedge clk);
        adc_stb = 1'b0;
      end
    end
    finish_burst();
  endtask

  // Outputs change on the rising edge and are checked on the falling one
  always @(negedge clk) begin
    if (cycle > 0 && reset) begin
      assert (rx_stb == 1'b0 && rx_count == 32'd0) else begin
        other_errs++;
        $display("output strobe or counter active during reset at %0t ns", $time);
      end
    end else if (cycle > 0 && rx_stb) begin
      if (exp_cyc_q.size() == 0) begin
        other_errs++;
        $display("output strobe at %0t ns with no sample outstanding", $time);
      end else begin
        e_i   = exp_i_q.pop_front();
        e_q   = exp_q_q.pop_front();
        e_cyc = exp_cyc_q.pop_front();
        delivered++;
        assert (cycle == e_cyc) else begin
          mism_errs++;
          $display("mismatch at %0t ns: sample arrived in cycle %0d, expected %0d",
                   $time, cycle, e_cyc);
        end
        for (int c = 0; c < NC; c++) begin
          assert (rx_i[c*AW +: AW] == e_i[c*AW +: AW]) else begin
            mism_errs++;
            $display("mismatch at %0t ns: ch%0d I is %h, expected %h",
                     $time, c, rx_i[c*AW +: AW], e_i[c*AW +: AW]);
          end
          assert (rx_q[c*AW +: AW] == e_q[c*AW +: AW]) else begin
            mism_errs++;
            $display("mismatch at %0t ns: ch%0d Q is %h, expected %h",
                     $time, c, rx_q[c*AW +: AW], e_q[c*AW +: AW]);
          end
        end
        assert (rx_count == 32'(delivered)) else begin
          mism_errs++;
          $display("mismatch at %0t ns: sample count is %0d, expected %0d",
                   $time, rx_count, delivered);
        end
      end
    end
  end

  // Watchdog sized from the stimulus bounds
  initial begin
    #(TIMEOUT_NS);
    $display("run did not finish within %0d ns, stimulus or output is stuck", TIMEOUT_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    sync     = 1'b0;
    set_stb  = 1'b0;
    set_addr = '0;
    set_data = '0;
    adc_stb  = 1'b0;
    adc_i    = '0;
    adc_q    = '0;
    for (int c = 0; c < NC; c++) begin
      m_mag[c]   = 0;
      m_phc[c]   = 0;
      m_off_i[c] = 0;
      m_off_q[c] = 0;
      m_map[c]   = '0;
      m_dir[c]   = 1'b0;
      m_nco[c]   = 0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Zero registers pass samples unchanged both back to back and with gaps
    send_random(32, 1'b0);
    send_random(16, 1'b1);

    // Every mapping combination on channel 0 while channel 1 holds its own
    write_reg(1, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_0009);
    for (int m = 0; m < 16; m++) begin
      write_reg(0, rx_frontend_pkg::SR_IQ_MAP, 32'(m));
      send_random(4, 1'b0);
    end
    write_reg(0, rx_frontend_pkg::SR_IQ_MAP, 32'h0);
    write_reg(1, rx_frontend_pkg::SR_IQ_MAP, 32'h0);
    // A channel number past the last one must not land anywhere
    write_reg(2, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_000C);
    send_random(4, 1'b0);

    // Offsets with full-scale inputs pushed past the rails
    write_reg(0, rx_frontend_pkg::SR_OFFSET_I, 32'hFF00_1234);
    write_reg(0, rx_frontend_pkg::SR_OFFSET_Q, 32'h00FB_0000);
    write_reg(1, rx_frontend_pkg::SR_OFFSET_I, 32'h007F_FF00);
    write_reg(1, rx_frontend_pkg::SR_OFFSET_Q, 32'h0080_0100);
    send_random(8, 1'b0);
    send_sample({NC{16'h8000}}, {NC{16'h7FFF}});
    send_sample({NC{16'h7FFF}}, {NC{16'h8000}});
    finish_burst();
    for (int c = 0; c < NC; c++) begin
      write_reg(c, rx_frontend_pkg::SR_OFFSET_I, 32'h0);
      write_reg(c, rx_frontend_pkg::SR_OFFSET_Q, 32'h0);
    end

    // Imbalance where channel 1 takes the largest coefficients to hit saturation
    write_reg(0, rx_frontend_pkg::SR_MAG, 32'h0000_8000);
    write_reg(0, rx_frontend_pkg::SR_PHASE, 32'hFFFF_C000);
    write_reg(1, rx_frontend_pkg::SR_MAG, 32'h0001_FFFF);
    write_reg(1, rx_frontend_pkg::SR_PHASE, 32'h0002_0000);
    send_random(8, 1'b0);
    send_sample({NC{16'h7FFF}}, {NC{16'h7FFF}});
    send_sample({NC{16'h8000}}, {NC{16'h0000}});
    send_sample({NC{16'h4000}}, {NC{16'h7F00}});
    finish_burst();
    for (int c = 0; c < NC; c++) begin
      write_reg(c, rx_frontend_pkg::SR_MAG, 32'h0);
      write_reg(c, rx_frontend_pkg::SR_PHASE, 32'h0);
    end

    // Mixer in both directions is restarted by sync and by a direction write
    write_reg(0, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_0010);
    write_reg(1, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_0010);
    write_reg(0, rx_frontend_pkg::SR_HET_DIR, 32'h0);
    write_reg(1, rx_frontend_pkg::SR_HET_DIR, 32'h1);
    // Odd sample counts leave the phase away from zero before each restart
    send_random(7, 1'b0);
    pulse_sync();
    for (int k = 0; k < 4; k++) begin
      send_sample({NC{16'h8000}}, {NC{16'h8000}});
    end
    finish_burst();
    send_random(3, 1'b0);
    write_reg(0, rx_frontend_pkg::SR_HET_DIR, 32'h1);
    send_random(5, 1'b1);
    for (int c = 0; c < NC; c++) begin
      write_reg(c, rx_frontend_pkg::SR_IQ_MAP, 32'h0);
      write_reg(c, rx_frontend_pkg::SR_HET_DIR, 32'h0);
    end

    // Bypass returns raw samples over active corrections, then the corrections show
    write_reg(0, rx_frontend_pkg::SR_MAG, 32'h0000_8000);
    write_reg(0, rx_frontend_pkg::SR_OFFSET_I, 32'h0000_1000);
    write_reg(1, rx_frontend_pkg::SR_PHASE, 32'h0003_C000);
    write_reg(1, rx_frontend_pkg::SR_OFFSET_Q, 32'h00FF_F000);
    write_reg(0, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_009D);
    write_reg(1, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_008A);
    send_random(16, 1'b0);
    write_reg(0, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_001D);
    write_reg(1, rx_frontend_pkg::SR_IQ_MAP, 32'h0000_000A);
    send_random(4, 1'b0);

    assert (rx_count == 32'(sent)) else begin
      mism_errs++;
      $display("mismatch at %0t ns: final count is %0d, expected %0d", $time, rx_count, sent);
    end
    $display("%0d mismatches, %0d other errors, %0d of %0d samples checked",
             mism_errs, other_errs, delivered, sent);
    if (mism_errs == 0 && other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: rx_frontend_top.sv
// RX frontend top level
`timescale 1ns/1ps
module rx_frontend_top (
  input  logic                                                        clk,
  input  logic                                                        reset,
  input  logic                                                        sync_i,
  input  logic                                                        set_stb_i,
  input  logic [7:0]                                                  set_addr_i,
  input  logic [31:0]                                                 set_data_i,
  input  logic                                                        adc_stb_i,
  input  logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0] adc_i_i,
  input  logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0] adc_q_i,
  output logic                                                        rx_stb_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0] rx_i_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0] rx_q_o,
  output logic [31:0]                                                 rx_count_o
);

  localparam int NC = rx_frontend_pkg::NUM_CHAN;
  localparam int AW = rx_frontend_pkg::ADC_W;
  localparam int DW = rx_frontend_pkg::DSP_W;
  localparam int CW = rx_frontend_pkg::CORR_W;

  logic [NC*CW-1:0] mag;
  logic [NC*CW-1:0] phase;
  logic [NC*DW-1:0] offset_i;
  logic [NC*DW-1:0] offset_q;
  logic [NC*8-1:0]  map;
  logic [NC-1:0]    dir;
  logic [NC-1:0]    dir_wr;
  logic [NC-1:0]    ch_stb;
  logic [NC*AW-1:0] ch_i;
  logic [NC*AW-1:0] ch_q;

  frontend_settings settings_i (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .mag_o(mag), .phase_o(phase), .offset_i_o(offset_i),
    .offset_q_o(offset_q), .map_o(map), .dir_o(dir), .dir_wr_o(dir_wr)
  );

  for (genvar c = 0; c < NC; c++) begin : g_chan
    rx_frontend_channel chan_i (
      .clk(clk), .reset(reset), .sync_i(sync_i), .adc_stb_i(adc_stb_i),
      .adc_i_i(adc_i_i[c*AW +: AW]), .adc_q_i(adc_q_i[c*AW +: AW]),
      .mag_i(mag[c*CW +: CW]), .phase_i(phase[c*CW +: CW]),
      .offset_i_i(offset_i[c*DW +: DW]), .offset_q_i(offset_q[c*DW +: DW]),
      .map_i(map[c*8 +: 8]), .dir_i(dir[c]), .dir_wr_i(dir_wr[c]),
      .rx_stb_o(ch_stb[c]), .rx_i_o(ch_i[c*AW +: AW]), .rx_q_o(ch_q[c*AW +: AW])
    );
  end

  // All channels see one input strobe, so channel 0 speaks for the set
  rx_sample_collector collector_i (
    .clk(clk), .reset(reset), .ch_stb_i(ch_stb[0]), .ch_i_i(ch_i), .ch_q_i(ch_q),
    .rx_stb_o(rx_stb_o), .rx_i_o(rx_i_o), .rx_q_o(rx_q_o), .rx_count_o(rx_count_o)
  );

endmodule

// File: rx_sample_collector.sv
// Multi-channel sample collector
`timescale 1ns/1ps
module rx_sample_collector (
  input  logic                                                          clk,
  input  logic                                                          reset,
  input  logic                                                          ch_stb_i,
  input  logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0]   ch_i_i,
  input  logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0]   ch_q_i,
  output logic                                                          rx_stb_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0]   rx_i_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::ADC_W-1:0]   rx_q_o,
  output logic [31:0]                                                   rx_count_o
);

  // Count moves on the same edge that presents the sample set
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_stb_o   <= 1'b0;
      rx_count_o <= '0;
    end else begin
      rx_stb_o <= ch_stb_i;
      if (ch_stb_i) begin
        rx_count_o <= rx_count_o + 32'd1;
      end
    end
  end

  // Outputs hold the last delivered set between strobes
  always_ff @(posedge clk) begin
    if (ch_stb_i) begin
      rx_i_o <= ch_i_i;
      rx_q_o <= ch_q_i;
    end
  end

endmodule

// File: rx_frontend_channel.sv
// One receive correction channel
`timescale 1ns/1ps
module rx_frontend_channel (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               sync_i,
  input  logic                               adc_stb_i,
  input  logic [rx_frontend_pkg::ADC_W-1:0]  adc_i_i,
  input  logic [rx_frontend_pkg::ADC_W-1:0]  adc_q_i,
  input  logic [rx_frontend_pkg::CORR_W-1:0] mag_i,
  input  logic [rx_frontend_pkg::CORR_W-1:0] phase_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  offset_i_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  offset_q_i,
  input  logic [7:0]                         map_i,
  input  logic                               dir_i,
  input  logic                               dir_wr_i,
  output logic                               rx_stb_o,
  output logic [rx_frontend_pkg::ADC_W-1:0]  rx_i_o,
  output logic [rx_frontend_pkg::ADC_W-1:0]  rx_q_o
);

  rx_frontend_pkg::iq_map_t          map;
  logic                              m_stb;
  logic                              d_stb;
  logic                              c_stb;
  logic                              h_stb;
  logic [rx_frontend_pkg::DSP_W-1:0] m_i;
  logic [rx_frontend_pkg::DSP_W-1:0] m_q;
  logic [rx_frontend_pkg::DSP_W-1:0] d_i;
  logic [rx_frontend_pkg::DSP_W-1:0] d_q;
  logic [rx_frontend_pkg::DSP_W-1:0] c_i;
  logic [rx_frontend_pkg::DSP_W-1:0] c_q;
  logic [rx_frontend_pkg::DSP_W-1:0] h_i;
  logic [rx_frontend_pkg::DSP_W-1:0] h_q;
  logic [rx_frontend_pkg::ADC_W-1:0] raw_i [5];
  logic [rx_frontend_pkg::ADC_W-1:0] raw_q [5];

  assign map = map_i;

  // Round half up by adding half an output LSB, clamping only on positive overflow
  function automatic logic [rx_frontend_pkg::ADC_W-1:0] round_sat(
    input logic [rx_frontend_pkg::DSP_W-1:0] x
  );
    logic [rx_frontend_pkg::DSP_W:0] sum;
    sum = {x[rx_frontend_pkg::DSP_W-1], x} + 25'h80;
    if (sum[rx_frontend_pkg::DSP_W:rx_frontend_pkg::DSP_W-1] == 2'b01) begin
      return {1'b0, {(rx_frontend_pkg::ADC_W-1){1'b1}}};
    end
    return sum[rx_frontend_pkg::DSP_W-1:rx_frontend_pkg::DSP_W-rx_frontend_pkg::ADC_W];
  endfunction

  iq_mapper mapper_i (
    .clk(clk), .reset(reset), .stb_i(adc_stb_i), .i_i(adc_i_i), .q_i(adc_q_i),
    .map_i(map_i), .stb_o(m_stb), .i_o(m_i), .q_o(m_q)
  );

  dc_offset_corr dc_i (
    .clk(clk), .reset(reset), .stb_i(m_stb), .i_i(m_i), .q_i(m_q),
    .offset_i_i(offset_i_i), .offset_q_i(offset_q_i),
    .stb_o(d_stb), .i_o(d_i), .q_o(d_q)
  );

  iq_imbalance_comp comp_i (
    .clk(clk), .reset(reset), .stb_i(d_stb), .i_i(d_i), .q_i(d_q),
    .mag_i(mag_i), .phase_i(phase_i), .stb_o(c_stb), .i_o(c_i), .q_o(c_q)
  );

  quarter_rate_dc qrdc_i (
    .clk(clk), .reset(reset), .sync_i(sync_i), .dir_wr_i(dir_wr_i), .dir_i(dir_i),
    .enable_i(map.downconvert), .stb_i(c_stb), .i_i(c_i), .q_i(c_q),
    .stb_o(h_stb), .i_o(h_i), .q_o(h_q)
  );

  // Raw samples ride five stages behind the input to meet the round stage
  always_ff @(posedge clk) begin
    raw_i[0] <= adc_i_i;
    raw_q[0] <= adc_q_i;
    for (int k = 1; k < 5; k++) begin
      raw_i[k] <= raw_i[k-1];
      raw_q[k] <= raw_q[k-1];
    end
  end

  // Bypass picks the untouched ADC sample but keeps the same latency
  always_ff @(posedge clk) begin
    rx_i_o <= map.bypass_all ? raw_i[4] : round_sat(h_i);
    rx_q_o <= map.bypass_all ? raw_q[4] : round_sat(h_q);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_stb_o <= 1'b0;
    end else begin
      rx_stb_o <= h_stb;
    end
  end

endmodule

// File: quarter_rate_dc.sv
// Quarter-rate downconverter
`timescale 1ns/1ps
module quarter_rate_dc (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               sync_i,
  input  logic                               dir_wr_i,
  input  logic                               dir_i,
  input  logic                               enable_i,
  input  logic                               stb_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  i_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  q_i,
  output logic                               stb_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  i_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  q_o
);

  logic [1:0]                               phase;
  logic [1:0]                               sel;
  logic signed [rx_frontend_pkg::DSP_W+1:0] neg_i;
  logic signed [rx_frontend_pkg::DSP_W+1:0] neg_q;
  logic [rx_frontend_pkg::DSP_W-1:0]        rot_i;
  logic [rx_frontend_pkg::DSP_W-1:0]        rot_q;

  // Phase moves one quarter turn per sample, also while the mixer is off
  always_ff @(posedge clk) begin
    if (reset || sync_i || dir_wr_i) begin
      phase <= 2'd0;
    end else if (stb_i) begin
      phase <= phase + 2'd1;
    end
  end

  // Rotating by -j to the n is the same as rotating by j to the -n
  assign sel   = dir_i ? 2'd0 - phase : phase;
  assign neg_i = -$signed(i_i);
  assign neg_q = -$signed(q_i);

  // Negating the most negative value clamps to the largest positive one
  always_comb begin
    rot_i = i_i;
    rot_q = q_i;
    case (sel)
      2'd1: begin
        rot_i = rx_frontend_pkg::sat_dsp(neg_q);
        rot_q = i_i;
      end
      2'd2: begin
        rot_i = rx_frontend_pkg::sat_dsp(neg_i);
        rot_q = rx_frontend_pkg::sat_dsp(neg_q);
      end
      2'd3: begin
        rot_i = q_i;
        rot_q = rx_frontend_pkg::sat_dsp(neg_i);
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  // Disabled mixer still costs one register stage so latency stays fixed
  always_ff @(posedge clk) begin
    i_o <= enable_i ? rot_i : i_i;
    q_o <= enable_i ? rot_q : q_i;
  end

endmodule

// File: iq_imbalance_comp.sv
// I/Q magnitude and phase imbalance correction
`timescale 1ns/1ps
module iq_imbalance_comp (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               stb_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  i_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  q_i,
  input  logic [rx_frontend_pkg::CORR_W-1:0] mag_i,
  input  logic [rx_frontend_pkg::CORR_W-1:0] phase_i,
  output logic                               stb_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  i_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  q_o
);

  logic signed [2*rx_frontend_pkg::CORR_W-1:0] prod_mag;
  logic signed [2*rx_frontend_pkg::CORR_W-1:0] prod_phase;
  logic [rx_frontend_pkg::DSP_W-1:0]           i_dly;
  logic [rx_frontend_pkg::DSP_W-1:0]           q_dly;
  logic                                        stb_dly;
  logic signed [rx_frontend_pkg::DSP_W+1:0]    i_sum;
  logic signed [rx_frontend_pkg::DSP_W+1:0]    q_sum;

  // Both rails are corrected from the top 18 bits of I in 1.17 format
  always_ff @(posedge clk) begin
    prod_mag   <= $signed(i_i[23:6]) * $signed(mag_i);
    prod_phase <= $signed(i_i[23:6]) * $signed(phase_i);
    i_dly      <= i_i;
    q_dly      <= q_i;
  end

  // A 2.34 product drops 11 bits to line up with the 1.23 sample
  assign i_sum = $signed(i_dly) + $signed(prod_mag[35:11]);
  assign q_sum = $signed(q_dly) + $signed(prod_phase[35:11]);

  always_ff @(posedge clk) begin
    i_o <= rx_frontend_pkg::sat_dsp(i_sum);
    q_o <= rx_frontend_pkg::sat_dsp(q_sum);
  end

  // Strobe follows the two register stages of the data
  always_ff @(posedge clk) begin
    if (reset) begin
      stb_dly <= 1'b0;
      stb_o   <= 1'b0;
    end else begin
      stb_dly <= stb_i;
      stb_o   <= stb_dly;
    end
  end

endmodule

// File: dc_offset_corr.sv
// Fixed DC offset removal
`timescale 1ns/1ps
module dc_offset_corr (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               stb_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  i_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  q_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  offset_i_i,
  input  logic [rx_frontend_pkg::DSP_W-1:0]  offset_q_i,
  output logic                               stb_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  i_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  q_o
);

  // Two guard bits hold the full range of the signed difference
  logic signed [rx_frontend_pkg::DSP_W+1:0] i_diff;
  logic signed [rx_frontend_pkg::DSP_W+1:0] q_diff;

  assign i_diff = $signed(i_i) - $signed(offset_i_i);
  assign q_diff = $signed(q_i) - $signed(offset_q_i);

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  // A large offset near full scale clamps instead of wrapping around
  always_ff @(posedge clk) begin
    i_o <= rx_frontend_pkg::sat_dsp(i_diff);
    q_o <= rx_frontend_pkg::sat_dsp(q_diff);
  end

endmodule

// File: iq_mapper.sv
// I/Q swap, inversion and real mode
`timescale 1ns/1ps
module iq_mapper (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               stb_i,
  input  logic [rx_frontend_pkg::ADC_W-1:0]  i_i,
  input  logic [rx_frontend_pkg::ADC_W-1:0]  q_i,
  input  logic [7:0]                         map_i,
  output logic                               stb_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  i_o,
  output logic [rx_frontend_pkg::DSP_W-1:0]  q_o
);

  rx_frontend_pkg::iq_map_t          map;
  logic [rx_frontend_pkg::ADC_W-1:0] i_sel;
  logic [rx_frontend_pkg::ADC_W-1:0] q_sel;

  assign map = map_i;

  // Inversion follows the input rail, so a swapped Q output uses invert_i
  always_comb begin
    if (map.swap_iq) begin
      i_sel = map.invert_q ? ~q_i : q_i;
      q_sel = map.invert_i ? ~i_i : i_i;
    end else begin
      i_sel = map.invert_i ? ~i_i : i_i;
      q_sel = map.invert_q ? ~q_i : q_i;
    end
    // Real mode ignores whatever lands on the Q rail
    if (map.realmode) begin
      q_sel = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  // ADC value goes to the top of the wider internal word
  always_ff @(posedge clk) begin
    i_o <= {i_sel, {(rx_frontend_pkg::DSP_W-rx_frontend_pkg::ADC_W){1'b0}}};
    q_o <= {q_sel, {(rx_frontend_pkg::DSP_W-rx_frontend_pkg::ADC_W){1'b0}}};
  end

endmodule

// File: frontend_settings.sv
// Frontend settings register bank
`timescale 1ns/1ps
module frontend_settings (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   set_stb_i,
  input  logic [7:0]                                             set_addr_i,
  input  logic [31:0]                                            set_data_i,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::CORR_W-1:0] mag_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::CORR_W-1:0] phase_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::DSP_W-1:0]  offset_i_o,
  output logic [rx_frontend_pkg::NUM_CHAN*rx_frontend_pkg::DSP_W-1:0]  offset_q_o,
  output logic [rx_frontend_pkg::NUM_CHAN*8-1:0]                 map_o,
  output logic [rx_frontend_pkg::NUM_CHAN-1:0]                   dir_o,
  output logic [rx_frontend_pkg::NUM_CHAN-1:0]                   dir_wr_o
);

  rx_frontend_pkg::set_word_u word;
  logic [3:0]                 chan;
  logic [3:0]                 index;

  // The same data word is read as a coefficient or as a mapping value
  assign word  = set_data_i;
  assign chan  = set_addr_i[7:4];
  assign index = set_addr_i[3:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      mag_o      <= '0;
      phase_o    <= '0;
      offset_i_o <= '0;
      offset_q_o <= '0;
      map_o      <= '0;
      dir_o      <= '0;
      dir_wr_o   <= '0;
    end else begin
      // Direction write pulse is high for one cycle, together with the new direction
      dir_wr_o <= '0;
      // Channel numbers at or above NUM_CHAN match no slice and are dropped
      for (int c = 0; c < rx_frontend_pkg::NUM_CHAN; c++) begin
        if (set_stb_i && chan == 4'(c)) begin
          case (index)
            rx_frontend_pkg::SR_MAG: begin
              mag_o[c*rx_frontend_pkg::CORR_W +: rx_frontend_pkg::CORR_W] <= word.coef.value;
            end
            rx_frontend_pkg::SR_PHASE: begin
              phase_o[c*rx_frontend_pkg::CORR_W +: rx_frontend_pkg::CORR_W] <= word.coef.value;
            end
            rx_frontend_pkg::SR_OFFSET_I: begin
              offset_i_o[c*rx_frontend_pkg::DSP_W +: rx_frontend_pkg::DSP_W] <= set_data_i[23:0];
            end
            rx_frontend_pkg::SR_OFFSET_Q: begin
              offset_q_o[c*rx_frontend_pkg::DSP_W +: rx_frontend_pkg::DSP_W] <= set_data_i[23:0];
            end
            rx_frontend_pkg::SR_IQ_MAP: begin
              map_o[c*8 +: 8] <= word.mapping.map;
            end
            rx_frontend_pkg::SR_HET_DIR: begin
              dir_o[c]    <= set_data_i[0];
              dir_wr_o[c] <= 1'b1;
            end
            default: begin
            end
          endcase
        end
      end
    end
  end

endmodule

// File: rx_frontend_pkg.sv
// RX frontend shared definitions
package rx_frontend_pkg;

  // Channel count and datapath widths
  localparam int NUM_CHAN = 2;
  localparam int ADC_W    = 16;
  localparam int DSP_W    = 24;
  localparam int CORR_W   = 18;

  // Register indices sit in the low address nibble
  // The high nibble of the address selects the channel
  localparam logic [3:0] SR_MAG      = 4'd0;
  localparam logic [3:0] SR_PHASE    = 4'd1;
  localparam logic [3:0] SR_OFFSET_I = 4'd2;
  localparam logic [3:0] SR_OFFSET_Q = 4'd3;
  localparam logic [3:0] SR_IQ_MAP   = 4'd4;
  localparam logic [3:0] SR_HET_DIR  = 4'd5;

  // Strobe-in to strobe-out latency of the whole frontend
  localparam int PIPE_LAT = 7;

  // Layout of the I/Q mapping register
  typedef struct packed {
    logic       bypass_all;
    logic [1:0] reserved;
    logic       downconvert;
    logic       invert_i;
    logic       invert_q;
    logic       realmode;
    logic       swap_iq;
  } iq_map_t;

  // Coefficient view of a settings word, upper bits are don't care
  typedef struct packed {
    logic [31-CORR_W:0]       unused;
    logic signed [CORR_W-1:0] value;
  } coef_word_t;

  // Mapping view of a settings word
  typedef struct packed {
    logic [23:0] unused;
    iq_map_t     map;
  } map_word_t;

  typedef union packed {
    coef_word_t coef;
    map_word_t  mapping;
  } set_word_u;

  // Clamp a value with two guard bits to the signed internal range
  function automatic logic [DSP_W-1:0] sat_dsp(input logic signed [DSP_W+1:0] x);
    if (x[DSP_W+1:DSP_W-1] == 3'b000 || x[DSP_W+1:DSP_W-1] == 3'b111) begin
      return x[DSP_W-1:0];
    end else if (x[DSP_W+1]) begin
      return {1'b1, {(DSP_W-1){1'b0}}};
    end
    return {1'b0, {(DSP_W-1){1'b1}}};
  endfunction

endpackage
